//--- logic/api_pkg.sv
package api_pkg;

	// Chain and word geometry.
	localparam int api_num = 10;
	localparam int word_w = 32;

	// A chip's job is 23 words long, and only the first 11 reply words are kept.
	localparam int work_len = 23;
	localparam int rx_block_len = 11;
	localparam int max_chip_in_ch = 5;

	localparam int rx_depth = 512;
	localparam int tx_depth = 512;
	localparam int cnt_w = 10;

	// The tag goes into bits 15:8 of the last word of each reply block.
	localparam logic [7:0] tag_byte = 8'h12;
	localparam logic [word_w-1:0] nonce_marker = 32'hbeafbeaf;

	// Quiet cycles between two jobs.
	localparam int nop_len = 15;

	typedef enum logic [1:0] {
		st_wait = 2'd0,
		st_work = 2'd1,
		st_nop  = 2'd2
	} api_state_t;

endpackage

//--- logic/api_fifo.sv
`timescale 1ns/1ps

module api_fifo #(
	parameter int depth = api_pkg::tx_depth
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        clr,
	input  logic                        wr_en,
	input  logic [api_pkg::word_w-1:0]  din,
	input  logic                        rd_en,
	output logic [api_pkg::word_w-1:0]  dout,
	output logic                        empty,
	output logic                        full,
	output logic [api_pkg::cnt_w-1:0]   count
);

	logic [api_pkg::word_w-1:0] mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr;
	logic [$clog2(depth)-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;
	assign empty = (count == '0);
	assign full = (count == api_pkg::cnt_w'(depth));

	// The head word is always visible on dout.
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (clr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == $clog2(depth)'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == $clog2(depth)'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
		else $error("api_fifo: write while full");
	a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty)
		else $error("api_fifo: read while empty");

endmodule

//--- logic/api_timer.sv
`timescale 1ns/1ps

module api_timer (
	input  logic        clk,
	input  logic        rst,
	input  logic        clr,
	input  logic [27:0] timeout,
	input  logic        start,
	output logic        busy
);

	logic [27:0] cnt;

	assign busy = (cnt != '0);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			cnt <= '0;
		else if (clr)
			cnt <= '0;
		else if (start)
			cnt <= timeout;
		else if (busy)
			cnt <= cnt - 1'b1;
	end

	// The sequencer only starts a job once the previous timeout has run out.
	a_start_idle: assert property (@(posedge clk) disable iff (rst || clr) start |-> !busy)
		else $error("api_timer: start while busy");

endmodule

//--- logic/api_phy.sv
`timescale 1ns/1ps

module api_phy (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        clr,
	input  logic [7:0]                  sck_div,
	input  logic                        mosi_vld,
	input  logic [api_pkg::word_w-1:0]  mosi_dat,
	output logic                        miso_vld,
	output logic [api_pkg::word_w-1:0]  miso_dat,
	output logic                        sck,
	output logic                        mosi,
	input  logic                        miso
);

	logic active;
	logic [7:0] div_cnt;
	logic [5:0] half_cnt;
	logic [api_pkg::word_w-1:0] shift_out;
	logic [api_pkg::word_w-1:0] shift_in;

	assign miso_dat = shift_in;

	// Each sck half period lasts sck_div+1 cycles, and a word takes 64 halves.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active <= 1'b0;
			div_cnt <= '0;
			half_cnt <= '0;
			sck <= 1'b0;
			mosi <= 1'b0;
			miso_vld <= 1'b0;
		end else if (clr) begin
			active <= 1'b0;
			div_cnt <= '0;
			half_cnt <= '0;
			sck <= 1'b0;
			mosi <= 1'b0;
			miso_vld <= 1'b0;
		end else begin
			miso_vld <= 1'b0;
			if (mosi_vld && !active) begin
				active <= 1'b1;
				div_cnt <= '0;
				half_cnt <= '0;
				sck <= 1'b0;
				mosi <= mosi_dat[api_pkg::word_w-1];
			end else if (active) begin
				if (div_cnt == sck_div) begin
					div_cnt <= '0;
					half_cnt <= half_cnt + 1'b1;
					sck <= ~sck;
					// The last falling edge ends the word.
					if (sck && half_cnt == 6'd63) begin
						active <= 1'b0;
						miso_vld <= 1'b1;
						mosi <= 1'b0;
					end else if (sck) begin
						mosi <= shift_out[api_pkg::word_w-2];
					end
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
			end
		end
	end

	// Data shifters carry no reset.
	always_ff @(posedge clk) begin
		if (mosi_vld && !active) begin
			shift_out <= mosi_dat;
		end else if (active && div_cnt == sck_div) begin
			if (sck)
				shift_out <= {shift_out[api_pkg::word_w-2:0], 1'b0};
			else
				shift_in <= {shift_in[api_pkg::word_w-2:0], miso};
		end
	end

	a_one_word: assert property (@(posedge clk) disable iff (rst) mosi_vld |-> !active)
		else $error("api_phy: request while a word is in flight");

endmodule

//--- logic/api_ctrl.sv
`timescale 1ns/1ps

module api_ctrl (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         clr,
	input  logic [27:0]                  timeout,
	input  logic [7:0]                   sck_div,
	input  logic [8:0]                   word_num,
	input  logic                         tx_empty,
	output logic                         tx_rd_en,
	input  logic [api_pkg::word_w-1:0]   tx_dout,
	output logic                         rx_wr_en,
	output logic [api_pkg::word_w-1:0]   rx_din,
	input  logic [api_pkg::cnt_w-1:0]    rx_count,
	output api_pkg::api_state_t          state,
	output logic                         busy,
	output logic [3:0]                   chain_id,
	output logic [4:0]                   work_cnt,
	output logic                         nonce_found,
	output logic [api_pkg::api_num-1:0]  load,
	output logic                         sck,
	output logic                         mosi,
	input  logic [api_pkg::api_num-1:0]  miso
);

	api_pkg::api_state_t nxt_state;
	logic [8:0] word_cnt;
	logic [3:0] nop_cnt;
	logic mosi_vld;
	logic miso_vld;
	logic [api_pkg::word_w-1:0] miso_dat;
	logic miso_w;
	logic job_start;
	logic chip_word;
	logic nonce_armed;
	logic [api_pkg::cnt_w-1:0] rx_free;
	logic rx_room;

	assign rx_free = api_pkg::cnt_w'(api_pkg::rx_depth) - rx_count;
	assign rx_room = rx_free >= api_pkg::cnt_w'(api_pkg::rx_block_len * api_pkg::max_chip_in_ch);
	assign job_start = (state != api_pkg::st_work) && (nxt_state == api_pkg::st_work);
	assign chip_word = (state == api_pkg::st_work) && miso_vld && (word_cnt != word_num);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= api_pkg::st_wait;
		else if (clr)
			state <= api_pkg::st_wait;
		else
			state <= nxt_state;
	end

	always_comb begin
		nxt_state = state;
		case (state)
			api_pkg::st_wait:
				if (!busy && !tx_empty && rx_room)
					nxt_state = api_pkg::st_work;
			api_pkg::st_work:
				if (word_cnt == word_num)
					nxt_state = api_pkg::st_nop;
			api_pkg::st_nop:
				if (nop_cnt == 4'(api_pkg::nop_len - 1))
					nxt_state = api_pkg::st_wait;
			default:
				nxt_state = api_pkg::st_wait;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			word_cnt <= '0;
			work_cnt <= '0;
			nop_cnt <= '0;
			mosi_vld <= 1'b0;
		end else if (clr) begin
			word_cnt <= '0;
			work_cnt <= '0;
			nop_cnt <= '0;
			mosi_vld <= 1'b0;
		end else begin
			// Next word goes out in the cycle after the previous reply.
			mosi_vld <= job_start || (chip_word && (word_cnt + 9'd1 < word_num));
			if (job_start) begin
				word_cnt <= '0;
				work_cnt <= '0;
			end else if (chip_word) begin
				word_cnt <= word_cnt + 1'b1;
				if (work_cnt == 5'(api_pkg::work_len - 1))
					work_cnt <= '0;
				else
					work_cnt <= work_cnt + 1'b1;
			end
			if (state == api_pkg::st_nop)
				nop_cnt <= nop_cnt + 1'b1;
			else
				nop_cnt <= '0;
		end
	end

	assign tx_rd_en = mosi_vld && (state == api_pkg::st_work);

	always_comb begin
		chain_id = 4'd0;
		for (int i = 0; i < api_pkg::api_num; i++) begin
			if (!load[i])
				chain_id = 4'(i);
		end
	end

	assign rx_wr_en = miso_vld && (state == api_pkg::st_work)
		&& (work_cnt < 5'(api_pkg::rx_block_len));
	assign rx_din = (work_cnt == 5'(api_pkg::rx_block_len - 1))
		? {miso_dat[31:16], api_pkg::tag_byte, 4'b0, chain_id}
		: miso_dat;

	// Armed by word 2 of a block, dropped when that block ends.
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			nonce_armed <= 1'b0;
		else if (clr || job_start)
			nonce_armed <= 1'b0;
		else if (rx_wr_en && work_cnt == 5'd2)
			nonce_armed <= 1'b1;
		else if (rx_wr_en && work_cnt == 5'(api_pkg::rx_block_len - 1))
			nonce_armed <= 1'b0;
	end

	assign nonce_found = nonce_armed && rx_wr_en
		&& (work_cnt == 5'(api_pkg::rx_block_len - 2))
		&& (miso_dat == api_pkg::nonce_marker);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			load <= ~api_pkg::api_num'(1);
		else if (clr)
			load <= ~api_pkg::api_num'(1);
		else if (state == api_pkg::st_nop && nxt_state == api_pkg::st_wait)
			load <= {load[api_pkg::api_num-2:0], load[api_pkg::api_num-1]};
	end

	// Unselected chains are forced high so only the active one reaches the phy.
	assign miso_w = &(miso | load);

	api_timer u_timer (
		.clk     (clk),
		.rst     (rst),
		.clr     (clr),
		.timeout (timeout),
		.start   (job_start),
		.busy    (busy)
	);

	api_phy u_phy (
		.clk      (clk),
		.rst      (rst),
		.clr      (clr),
		.sck_div  (sck_div),
		.mosi_vld (mosi_vld),
		.mosi_dat (tx_dout),
		.miso_vld (miso_vld),
		.miso_dat (miso_dat),
		.sck      (sck),
		.mosi     (mosi),
		.miso     (miso_w)
	);

	a_one_chain: assert property (@(posedge clk) disable iff (rst) $onehot(~load))
		else $error("api_ctrl: load must select exactly one chain");

endmodule

//--- logic/api_top.sv
`timescale 1ns/1ps

module api_top (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         cfg_rst,
	input  logic [27:0]                  cfg_timeout,
	input  logic [7:0]                   cfg_sck_div,
	input  logic [8:0]                   cfg_word_num,
	input  logic                         tx_wr_en,
	input  logic [api_pkg::word_w-1:0]   tx_din,
	output logic                         tx_full,
	input  logic                         rx_rd_en,
	output logic [api_pkg::word_w-1:0]   rx_dout,
	output logic                         rx_empty,
	output logic [api_pkg::cnt_w-1:0]    rx_count,
	output api_pkg::api_state_t          state,
	output logic                         busy,
	output logic [3:0]                   chain_id,
	output logic [4:0]                   work_cnt,
	output logic                         nonce_found,
	output logic [api_pkg::api_num-1:0]  load,
	output logic                         sck,
	output logic                         mosi,
	input  logic [api_pkg::api_num-1:0]  miso
);

	logic tx_rd_en;
	logic [api_pkg::word_w-1:0] tx_dout;
	logic tx_empty;
	logic rx_wr_en;
	logic [api_pkg::word_w-1:0] rx_din;

	api_fifo #(.depth(api_pkg::tx_depth)) tx_fifo (
		.clk   (clk),
		.rst   (rst),
		.clr   (cfg_rst),
		.wr_en (tx_wr_en),
		.din   (tx_din),
		.rd_en (tx_rd_en),
		.dout  (tx_dout),
		.empty (tx_empty),
		.full  (tx_full),
		.count ()
	);

	api_fifo #(.depth(api_pkg::rx_depth)) rx_fifo (
		.clk   (clk),
		.rst   (rst),
		.clr   (cfg_rst),
		.wr_en (rx_wr_en),
		.din   (rx_din),
		.rd_en (rx_rd_en),
		.dout  (rx_dout),
		.empty (rx_empty),
		.full  (),
		.count (rx_count)
	);

	api_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.clr         (cfg_rst),
		.timeout     (cfg_timeout),
		.sck_div     (cfg_sck_div),
		.word_num    (cfg_word_num),
		.tx_empty    (tx_empty),
		.tx_rd_en    (tx_rd_en),
		.tx_dout     (tx_dout),
		.rx_wr_en    (rx_wr_en),
		.rx_din      (rx_din),
		.rx_count    (rx_count),
		.state       (state),
		.busy        (busy),
		.chain_id    (chain_id),
		.work_cnt    (work_cnt),
		.nonce_found (nonce_found),
		.load        (load),
		.sck         (sck),
		.mosi        (mosi),
		.miso        (miso)
	);

endmodule

//--- sim/tb_api.sv
`timescale 1ns/1ps

module tb_api;

	localparam int clk_half = 50;

	logic clk;
	logic rst;
	logic cfg_rst;
	logic [27:0] cfg_timeout;
	logic [7:0] cfg_sck_div;
	logic [8:0] cfg_word_num;
	logic tx_wr_en;
	logic [31:0] tx_din;
	logic tx_full;
	logic rx_rd_en;
	logic [31:0] rx_dout;
	logic rx_empty;
	logic [api_pkg::cnt_w-1:0] rx_count;
	api_pkg::api_state_t state;
	logic busy;
	logic [3:0] chain_id;
	logic [4:0] work_cnt;
	logic nonce_found;
	logic [api_pkg::api_num-1:0] load;
	logic sck;
	logic mosi;
	logic [api_pkg::api_num-1:0] miso;

	integer seed;
	int errors;
	int err0;
	int tests_run;
	int tests_failed;
	int job_no;
	int tx_pops;
	int nonce_pulses;
	int nonce_at;
	int reply_idx;
	int bit_no;
	int mosi_bits;
	logic [31:0] reply_sr;
	logic [31:0] cur_reply;
	logic [31:0] mosi_sr;
	logic [31:0] replies[$];
	logic [31:0] mosi_words[$];
	logic [31:0] exp_tx[$];
	logic [31:0] exp_rx[$];

	api_top dut0 (
		.clk          (clk),
		.rst          (rst),
		.cfg_rst      (cfg_rst),
		.cfg_timeout  (cfg_timeout),
		.cfg_sck_div  (cfg_sck_div),
		.cfg_word_num (cfg_word_num),
		.tx_wr_en     (tx_wr_en),
		.tx_din       (tx_din),
		.tx_full      (tx_full),
		.rx_rd_en     (rx_rd_en),
		.rx_dout      (rx_dout),
		.rx_empty     (rx_empty),
		.rx_count     (rx_count),
		.state        (state),
		.busy         (busy),
		.chain_id     (chain_id),
		.work_cnt     (work_cnt),
		.nonce_found  (nonce_found),
		.load         (load),
		.sck          (sck),
		.mosi         (mosi),
		.miso         (miso)
	);

	always #clk_half clk = ~clk;

	// Only the selected chain answers; the others pull their line low.
	assign miso = ~load & {api_pkg::api_num{reply_sr[31]}};

	task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	function automatic logic [31:0] load_for_chain(input int chain);
		logic [api_pkg::api_num-1:0] sel;
		sel = ~(api_pkg::api_num'(1) << chain);
		return 32'(sel);
	endfunction

	function automatic int word_cycles(input int div);
		return 64 * (div + 1) + 3;
	endfunction

	function automatic int job_cycles(input int n, input int div, input int timeout);
		return n * word_cycles(div) + api_pkg::nop_len + timeout + 20;
	endfunction

	task automatic load_reply();
		if (reply_idx == nonce_at)
			cur_reply = api_pkg::nonce_marker;
		else
			cur_reply = $random(seed);
		reply_idx++;
		reply_sr = cur_reply;
	endtask

	task automatic reset_model();
		replies.delete();
		mosi_words.delete();
		exp_tx.delete();
		exp_rx.delete();
		bit_no = 0;
		mosi_bits = 0;
		reply_idx = 0;
		nonce_at = -1;
		job_no = 0;
		load_reply();
	endtask

	// Chain model. A reply bit changes after each falling sck edge.
	always @(negedge sck) begin
		#1;
		if (!rst && !cfg_rst) begin
			bit_no++;
			if (bit_no == api_pkg::word_w) begin
				replies.push_back(cur_reply);
				bit_no = 0;
				load_reply();
			end else begin
				reply_sr = reply_sr << 1;
			end
		end
	end

	always @(posedge sck) begin
		#1;
		mosi_sr = {mosi_sr[30:0], mosi};
		mosi_bits++;
		if (mosi_bits == api_pkg::word_w) begin
			mosi_words.push_back(mosi_sr);
			mosi_bits = 0;
		end
	end

	always @(negedge clk) begin
		if (dut0.tx_rd_en)
			tx_pops++;
		if (nonce_found)
			nonce_pulses++;
	end

	task automatic wait_state(input api_pkg::api_state_t target, input bit equal,
		input int limit, input string what);
		int n;
		n = 0;
		while (((state == target) != equal) && n < limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		if ((state == target) != equal) begin
			errors++;
			$display("Timed out after %0d cycles waiting for %s", limit, what);
		end
	endtask

	task automatic push_words(input int n);
		tx_pops = 0;
		nonce_pulses = 0;
		for (int i = 0; i < n; i++) begin
			tx_din = $random(seed);
			tx_wr_en = 1'b1;
			exp_tx.push_back(tx_din);
			@(posedge clk);
			#1;
		end
		tx_wr_en = 1'b0;
	endtask

	// Builds the expected receive words of one job from the replies the chain sent.
	task automatic finish_job(input int n);
		int chain;
		int w;
		int exp_pulses;
		logic [31:0] r;
		chain = job_no % api_pkg::api_num;
		exp_pulses = 0;
		wait_state(api_pkg::st_work, 1'b1, int'(cfg_timeout) + 200, "job start");
		compare_value(32'(load), load_for_chain(chain), "load");
		compare_value(32'(chain_id), 32'(chain), "chain_id");
		wait_state(api_pkg::st_work, 1'b0, n * word_cycles(int'(cfg_sck_div)) + 50, "job end");
		wait_state(api_pkg::st_wait, 1'b1, api_pkg::nop_len + 5, "end of the gap");
		compare_value(replies.size(), n, "reply words sent by the chain");
		compare_value(32'(work_cnt), 32'(n % api_pkg::work_len), "chip word counter");
		for (int k = 0; k < n && replies.size() > 0; k++) begin
			r = replies.pop_front();
			w = k % api_pkg::work_len;
			if (w == api_pkg::rx_block_len - 1)
				exp_rx.push_back({r[31:16], api_pkg::tag_byte, 4'b0, 4'(chain)});
			else if (w < api_pkg::rx_block_len)
				exp_rx.push_back(r);
			if (w == api_pkg::rx_block_len - 2 && r == api_pkg::nonce_marker)
				exp_pulses++;
		end
		compare_value(tx_pops, n, "words popped from the transmit FIFO");
		compare_value(nonce_pulses, exp_pulses, "nonce pulses");
		compare_value(mosi_words.size(), n, "words seen on mosi");
		while (mosi_words.size() > 0 && exp_tx.size() > 0)
			compare_value(mosi_words.pop_front(), exp_tx.pop_front(), "mosi word");
		job_no++;
	endtask

	task automatic run_job(input int n);
		push_words(n);
		finish_job(n);
	endtask

	task automatic drain_rx();
		compare_value(32'(rx_count), 32'(exp_rx.size()), "receive fill level");
		while (exp_rx.size() > 0 && !rx_empty) begin
			compare_value(rx_dout, exp_rx.pop_front(), "receive word");
			rx_rd_en = 1'b1;
			@(posedge clk);
			#1;
			rx_rd_en = 1'b0;
		end
		if (exp_rx.size() > 0) begin
			errors++;
			$display("Receive FIFO ran empty with %0d words still expected", exp_rx.size());
			exp_rx.delete();
		end
		compare_value(32'(rx_empty), 32'd1, "receive FIFO empty after draining");
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, errors - err_before);
		end
	endtask

	initial begin
		int limit;
		limit = 3 * job_cycles(5, 1, 0) + 3 * job_cycles(46, 0, 0)
			+ 14 * job_cycles(2, 0, 0) + 2 * job_cycles(2, 0, 400) + api_pkg::tx_depth;
		repeat (2 * limit + 3000) @(posedge clk);
		$display("Watchdog expired: the tests did not finish in the expected time");
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		cfg_rst = 1'b0;
		cfg_timeout = '0;
		cfg_sck_div = 8'd1;
		cfg_word_num = 9'd5;
		tx_wr_en = 1'b0;
		tx_din = '0;
		rx_rd_en = 1'b0;
		seed = 32'h898a;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		tx_pops = 0;
		nonce_pulses = 0;
		reset_model();

		err0 = errors;
		repeat (2) @(posedge clk);
		#1;
		compare_value(32'(state), 32'(api_pkg::st_wait), "state in reset");
		compare_value(32'(load), load_for_chain(0), "load in reset");
		compare_value({29'b0, sck, mosi, nonce_found}, 32'd0, "sck, mosi, nonce in reset");
		rst = 1'b0;
		end_test("reset", err0);

		err0 = errors;
		repeat (3) run_job(5);
		drain_rx();
		end_test("transmit path", err0);

		err0 = errors;
		cfg_sck_div = 8'd0;
		cfg_word_num = 9'(2 * api_pkg::work_len);
		run_job(2 * api_pkg::work_len);
		compare_value(32'(rx_count), 32'(2 * api_pkg::rx_block_len), "words after two chips");
		drain_rx();
		end_test("receive path and tagging", err0);

		err0 = errors;
		cfg_word_num = 9'd2;
		repeat (12) run_job(2);
		drain_rx();
		end_test("chain rotation", err0);

		err0 = errors;
		repeat (40) begin
			@(posedge clk);
			#1;
			compare_value(32'(state), 32'(api_pkg::st_wait), "state with empty transmit FIFO");
		end
		cfg_timeout = 28'd400;
		run_job(2);
		compare_value(32'(busy), 32'd1, "busy after a short job");
		push_words(2);
		while (busy) begin
			compare_value(32'(state), 32'(api_pkg::st_wait), "state while busy");
			@(posedge clk);
			#1;
		end
		finish_job(2);
		cfg_timeout = '0;
		while (busy) begin
			@(posedge clk);
			#1;
		end
		drain_rx();
		end_test("start gating", err0);

		err0 = errors;
		cfg_word_num = 9'(2 * api_pkg::work_len);
		// The prefetched reply is word 0 of the next job.
		nonce_at = reply_idx - 1 + api_pkg::work_len + api_pkg::rx_block_len - 2;
		run_job(2 * api_pkg::work_len);
		compare_value(nonce_pulses, 32'd1, "nonce pulses with marker in second block");
		drain_rx();
		end_test("nonce pulse", err0);

		err0 = errors;
		cfg_word_num = 9'd2;
		run_job(2);
		cfg_sck_div = 8'd255;
		cfg_word_num = 9'(2 * api_pkg::work_len);
		push_words(2 * api_pkg::work_len);
		wait_state(api_pkg::st_work, 1'b1, 200, "job start before the soft clear");
		// The slow sck keeps all but the first job word in the transmit FIFO while it fills.
		for (int i = 0; i <= api_pkg::tx_depth - 2 * api_pkg::work_len; i++) begin
			compare_value(32'(tx_full), 32'd0, "tx_full before the transmit FIFO is full");
			tx_din = $random(seed);
			tx_wr_en = 1'b1;
			@(posedge clk);
			#1;
		end
		tx_wr_en = 1'b0;
		compare_value(32'(tx_full), 32'd1, "tx_full with a full transmit FIFO");
		cfg_rst = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		cfg_rst = 1'b0;
		@(posedge clk);
		#1;
		reset_model();
		compare_value(32'(state), 32'(api_pkg::st_wait), "state after soft clear");
		compare_value(32'(rx_empty), 32'd1, "receive FIFO empty after soft clear");
		compare_value(32'(rx_count), 32'd0, "receive fill after soft clear");
		compare_value(32'(tx_full), 32'd0, "tx_full after soft clear");
		compare_value(32'(load), load_for_chain(0), "load after soft clear");
		compare_value(32'(chain_id), 32'd0, "chain_id after soft clear");
		repeat (30) begin
			@(posedge clk);
			#1;
			compare_value(32'(state), 32'(api_pkg::st_wait), "state with cleared transmit FIFO");
		end
		cfg_sck_div = 8'd0;
		cfg_word_num = 9'd2;
		run_job(2);
		drain_rx();
		end_test("soft clear", err0);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- project.f
logic/api_pkg.sv
logic/api_fifo.sv
logic/api_timer.sv
logic/api_phy.sv
logic/api_ctrl.sv
logic/api_top.sv
sim/tb_api.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"
mkdir -p build
verilator --binary --timing --assert -Wno-fatal --top-module tb_api -f project.f -Mdir build/obj
./build/obj/Vtb_api | tee build/sim.log
if grep -q "STATUS: FAIL" build/sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failures"
